/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// Widths
	localparam int data_w = 8;
	localparam int sel_w = 5;
	localparam int num_regs = 4;
	localparam int alu_op_w = 3;
	localparam int cycle_w = 3;

	// Opcodes, first byte of every instruction
	localparam logic [data_w-1:0] op_halt = 8'h00;
	localparam logic [data_w-1:0] op_noop = 8'h01;
	localparam logic [data_w-1:0] op_jump = 8'h03;
	localparam logic [data_w-1:0] op_math = 8'h04;
	localparam logic [data_w-1:0] op_ldfi = 8'h06;
	localparam logic [data_w-1:0] op_cpfr = 8'h08;
	localparam logic [data_w-1:0] op_stom = 8'h09;
	localparam logic [data_w-1:0] op_jinz = 8'h0a;

	// Bus sources; a register code in a program byte is its select code
	localparam logic [sel_w-1:0] sel_reg0 = 5'd0;
	localparam logic [sel_w-1:0] sel_reg1 = 5'd1;
	localparam logic [sel_w-1:0] sel_reg2 = 5'd2;
	localparam logic [sel_w-1:0] sel_reg3 = 5'd3;
	localparam logic [sel_w-1:0] sel_d_in = 5'd8;
	localparam logic [sel_w-1:0] sel_rax = 5'd9;
	localparam logic [sel_w-1:0] sel_ram = 5'd10;
	localparam logic [sel_w-1:0] sel_rip = 5'd11;
	localparam logic [sel_w-1:0] sel_rip_1 = 5'd12;
	localparam logic [sel_w-1:0] sel_zero = 5'd13;

	// ALU operations
	localparam logic [alu_op_w-1:0] alu_add = 3'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
	localparam logic [alu_op_w-1:0] alu_and = 3'd2;
	localparam logic [alu_op_w-1:0] alu_or = 3'd3;
	localparam logic [alu_op_w-1:0] alu_xor = 3'd4;

	// Controller word to the datapath
	typedef struct packed {
		logic [sel_w-1:0] select;
		logic load_addr;
		logic load_rip;
		logic load_alu;
		logic write_ram;
		logic [num_regs-1:0] load_reg;
	} ctrl_t;

	typedef struct packed {
		logic carry;
		logic equal;
		logic zero;
	} flags_t;

endpackage

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
	input wire [cpu_pkg::data_w-1:0] i_a,
	input wire [cpu_pkg::data_w-1:0] i_b,
	input wire [cpu_pkg::data_w-1:0] i_op,
	output logic [cpu_pkg::data_w-1:0] o_result,
	output cpu_pkg::flags_t o_flags
);
	// Extra top bit carries out of add and borrows out of subtract
	logic [cpu_pkg::data_w:0] m_wide;

	always_comb begin
		case (i_op[cpu_pkg::alu_op_w-1:0])
			cpu_pkg::alu_add: m_wide = {1'b0, i_a} + {1'b0, i_b};
			cpu_pkg::alu_sub: m_wide = {1'b0, i_a} - {1'b0, i_b};
			cpu_pkg::alu_and: m_wide = {1'b0, i_a & i_b};
			cpu_pkg::alu_or: m_wide = {1'b0, i_a | i_b};
			cpu_pkg::alu_xor: m_wide = {1'b0, i_a ^ i_b};
			default: m_wide = '0;
		endcase
	end

	assign o_result = m_wide[cpu_pkg::data_w-1:0];

	// Equal looks at the operands, zero at the result
	assign o_flags = '{
		carry: m_wide[cpu_pkg::data_w],
		equal: (i_a == i_b),
		zero: (m_wide[cpu_pkg::data_w-1:0] == '0)
	};
endmodule

`default_nettype wire

/* cpu_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_ram (
	input wire i_clk,
	input wire [cpu_pkg::data_w-1:0] i_addr,
	input wire [cpu_pkg::data_w-1:0] i_wdata,
	input wire i_we,
	output logic [cpu_pkg::data_w-1:0] o_q
);
	logic [cpu_pkg::data_w-1:0] m_mem [2**cpu_pkg::data_w];

	// Write-first, so a write shows up on the read port next cycle
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			m_mem[i_addr] <= i_wdata;
			o_q <= i_wdata;
		end else begin
			o_q <= m_mem[i_addr];
		end
	end
endmodule

`default_nettype wire

/* cpu_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_regs (
	input wire i_clk,
	input wire i_reset,
	input wire cpu_pkg::ctrl_t i_ctrl,
	input wire [cpu_pkg::data_w-1:0] i_data_in,
	input wire [cpu_pkg::data_w-1:0] i_ram_q,
	input wire [cpu_pkg::data_w-1:0] i_alu_result,
	input wire cpu_pkg::flags_t i_alu_flags,
	output logic [cpu_pkg::data_w-1:0] o_bus,
	output logic [cpu_pkg::data_w-1:0] o_mar,
	output logic [cpu_pkg::data_w-1:0] o_r0,
	output logic [cpu_pkg::data_w-1:0] o_r1,
	output cpu_pkg::flags_t o_flags
);
	logic [cpu_pkg::data_w-1:0] m_rip;
	logic [cpu_pkg::data_w-1:0] m_rax;
	logic [cpu_pkg::data_w-1:0] m_gpr [cpu_pkg::num_regs];
	logic m_sel_defined;
	logic m_any_enable;

	// Internal byte bus
	always_comb begin
		case (i_ctrl.select)
			cpu_pkg::sel_reg0: o_bus = m_gpr[0];
			cpu_pkg::sel_reg1: o_bus = m_gpr[1];
			cpu_pkg::sel_reg2: o_bus = m_gpr[2];
			cpu_pkg::sel_reg3: o_bus = m_gpr[3];
			cpu_pkg::sel_d_in: o_bus = i_data_in;
			cpu_pkg::sel_rax: o_bus = m_rax;
			cpu_pkg::sel_ram: o_bus = i_ram_q;
			cpu_pkg::sel_rip: o_bus = m_rip;
			cpu_pkg::sel_rip_1: o_bus = m_rip + 1'b1;
			cpu_pkg::sel_zero: o_bus = '0;
			default: o_bus = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_mar <= '0;
			m_rip <= '0;
			o_flags <= '0;
		end else begin
			if (i_ctrl.load_addr)
				o_mar <= o_bus;
			if (i_ctrl.load_rip)
				m_rip <= o_bus;
			if (i_ctrl.load_alu)
				o_flags <= i_alu_flags;
		end
	end

	// Accumulator and general registers
	always_ff @(posedge i_clk) begin
		if (i_ctrl.load_alu)
			m_rax <= i_alu_result;
		for (int i = 0; i < cpu_pkg::num_regs; i++) begin
			if (i_ctrl.load_reg[i])
				m_gpr[i] <= o_bus;
		end
	end

	assign o_r0 = m_gpr[0];
	assign o_r1 = m_gpr[1];

	assign m_sel_defined = (i_ctrl.select <= cpu_pkg::sel_reg3) ||
		(i_ctrl.select >= cpu_pkg::sel_d_in && i_ctrl.select <= cpu_pkg::sel_zero);
	assign m_any_enable = i_ctrl.load_addr | i_ctrl.load_rip | i_ctrl.load_alu |
		i_ctrl.write_ram | (|i_ctrl.load_reg);

	// A program byte with a bad register code must not reach a load
	a_select_defined: assert property (@(posedge i_clk) disable iff (i_reset)
		m_any_enable |-> m_sel_defined)
		else $error("undefined bus select %0d with a load enabled", i_ctrl.select);
endmodule

`default_nettype wire

/* cpu_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
	input wire i_clk,
	input wire i_reset,
	input wire i_load_addr,
	input wire i_load_data,
	input wire i_execute,
	input wire [cpu_pkg::data_w-1:0] i_ram_q,
	input wire cpu_pkg::flags_t i_flags,
	output cpu_pkg::ctrl_t o_ctrl,
	output logic o_waiting
);
	typedef enum logic [3:0] {
		st_load_addr,
		st_load_addr_wait,
		st_load_data,
		st_load_data_wait,
		st_pre_execute,
		st_fetch,
		st_inc_rip,
		st_halt,
		st_noop,
		st_jump,
		st_math,
		st_ldfi,
		st_cpfr,
		st_stom,
		st_jinz
	} state_t;

	state_t m_state;
	state_t m_next;
	logic [cpu_pkg::cycle_w-1:0] m_cycle;
	logic [cpu_pkg::sel_w-1:0] m_code;
	logic m_latch_code;

	// Unknown opcodes fall into HALT
	function automatic state_t decode_op(input logic [cpu_pkg::data_w-1:0] op);
		case (op)
			cpu_pkg::op_halt: decode_op = st_halt;
			cpu_pkg::op_noop: decode_op = st_noop;
			cpu_pkg::op_jump: decode_op = st_jump;
			cpu_pkg::op_math: decode_op = st_math;
			cpu_pkg::op_ldfi: decode_op = st_ldfi;
			cpu_pkg::op_cpfr: decode_op = st_cpfr;
			cpu_pkg::op_stom: decode_op = st_stom;
			cpu_pkg::op_jinz: decode_op = st_jinz;
			default: decode_op = st_halt;
		endcase
	endfunction

	// One-hot load enable for a register code and none for any other code
	function automatic logic [cpu_pkg::num_regs-1:0] reg_onehot(
		input logic [cpu_pkg::sel_w-1:0] code
	);
		reg_onehot = '0;
		if (code <= cpu_pkg::sel_reg3)
			reg_onehot[code[1:0]] = 1'b1;
	endfunction

	assign o_waiting = (m_state == st_load_addr);

	always_comb begin
		m_next = m_state;
		case (m_state)
			st_load_addr: begin
				if (i_load_addr)
					m_next = st_load_addr_wait;
				else if (i_execute)
					m_next = st_pre_execute;
			end
			st_load_addr_wait: if (!i_load_addr) m_next = st_load_data;
			st_load_data: if (i_load_data) m_next = st_load_data_wait;
			st_load_data_wait: if (!i_load_data) m_next = st_load_addr;
			st_pre_execute: if (!i_execute) m_next = st_fetch;
			st_fetch, st_inc_rip: if (m_cycle == 2) m_next = decode_op(i_ram_q);
			st_halt: m_next = st_load_addr;
			st_noop: m_next = st_inc_rip;
			st_jump: if (m_cycle == 2) m_next = st_fetch;
			st_math: if (m_cycle == 2) m_next = st_inc_rip;
			st_ldfi, st_cpfr: if (m_cycle == 3) m_next = st_inc_rip;
			st_stom: if (m_cycle == 4) m_next = st_inc_rip;
			st_jinz: begin
				// With zero set the operand was already stepped over in cycle 0
				if (m_cycle == 0 && i_flags.zero)
					m_next = st_inc_rip;
				else if (m_cycle == 2)
					m_next = st_fetch;
			end
			default: m_next = st_load_addr;
		endcase
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.select = cpu_pkg::sel_zero;
		m_latch_code = 1'b0;
		case (m_state)
			st_load_addr: if (i_load_addr) begin
				o_ctrl.select = cpu_pkg::sel_d_in;
				o_ctrl.load_addr = 1'b1;
			end
			st_load_data: if (i_load_data) begin
				o_ctrl.select = cpu_pkg::sel_d_in;
				o_ctrl.write_ram = 1'b1;
			end
			st_pre_execute: begin
				o_ctrl.load_rip = 1'b1;
				o_ctrl.load_addr = 1'b1;
			end
			st_fetch: if (m_cycle == 0) begin
				o_ctrl.select = cpu_pkg::sel_rip;
				o_ctrl.load_addr = 1'b1;
			end
			st_inc_rip, st_math, st_jinz: begin
				if (m_cycle == 0) begin
					o_ctrl.select = cpu_pkg::sel_rip_1;
					o_ctrl.load_rip = 1'b1;
					o_ctrl.load_addr = 1'b1;
				end else if (m_cycle == 2 && m_state == st_math) begin
					o_ctrl.load_alu = 1'b1;
				end else if (m_cycle == 2 && m_state == st_jinz) begin
					o_ctrl.select = cpu_pkg::sel_ram;
					o_ctrl.load_rip = 1'b1;
				end
			end
			st_jump: begin
				// Only MAR moves to the operand and RIP takes the target directly
				if (m_cycle == 0) begin
					o_ctrl.select = cpu_pkg::sel_rip_1;
					o_ctrl.load_addr = 1'b1;
				end else if (m_cycle == 2) begin
					o_ctrl.select = cpu_pkg::sel_ram;
					o_ctrl.load_rip = 1'b1;
				end
			end
			st_ldfi, st_cpfr, st_stom: begin
				if (m_cycle <= 1) begin
					// Step RIP over both operand bytes
					o_ctrl.select = cpu_pkg::sel_rip_1;
					o_ctrl.load_rip = 1'b1;
					o_ctrl.load_addr = 1'b1;
				end else if (m_cycle == 2) begin
					m_latch_code = 1'b1;
				end else if (m_state == st_ldfi) begin
					o_ctrl.select = cpu_pkg::sel_ram;
					o_ctrl.load_reg = reg_onehot(m_code);
				end else if (m_state == st_cpfr) begin
					// Second operand byte is the source register code
					o_ctrl.select = i_ram_q[cpu_pkg::sel_w-1:0];
					o_ctrl.load_reg = reg_onehot(m_code);
				end else if (m_cycle == 3) begin
					o_ctrl.select = cpu_pkg::sel_ram;
					o_ctrl.load_addr = 1'b1;
				end else begin
					o_ctrl.select = m_code;
					o_ctrl.write_ram = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			m_state <= st_load_addr;
			m_cycle <= '0;
		end else begin
			m_state <= m_next;
			// Saturate so that cycle 0 actions never repeat
			if (m_next != m_state)
				m_cycle <= '0;
			else if (m_cycle != '1)
				m_cycle <= m_cycle + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (m_latch_code)
			m_code <= i_ram_q[cpu_pkg::sel_w-1:0];
	end

	// The destination code of LDFI or CPFR must name exactly one register
	a_load_reg_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		(m_state inside {st_ldfi, st_cpfr} && m_cycle == 3) |-> $onehot(o_ctrl.load_reg))
		else $error("register load without a single destination register");
endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input wire i_clk,
	input wire i_reset,
	input wire i_load_addr,
	input wire i_load_data,
	input wire i_execute,
	input wire [cpu_pkg::data_w-1:0] i_data_in,
	output logic [cpu_pkg::data_w-1:0] o_data_out,
	output logic o_waiting
);
	cpu_pkg::ctrl_t m_ctrl;
	cpu_pkg::flags_t m_alu_flags;
	cpu_pkg::flags_t m_flags;
	logic [cpu_pkg::data_w-1:0] m_bus;
	logic [cpu_pkg::data_w-1:0] m_mar;
	logic [cpu_pkg::data_w-1:0] m_r0;
	logic [cpu_pkg::data_w-1:0] m_r1;
	logic [cpu_pkg::data_w-1:0] m_ram_q;
	logic [cpu_pkg::data_w-1:0] m_alu_result;

	// Front panel shows whatever the RAM reads at MAR
	assign o_data_out = m_ram_q;

	cpu_control u_control (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.i_execute(i_execute),
		.i_ram_q(m_ram_q),
		.i_flags(m_flags),
		.o_ctrl(m_ctrl),
		.o_waiting(o_waiting)
	);

	cpu_regs u_regs (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ctrl(m_ctrl),
		.i_data_in(i_data_in),
		.i_ram_q(m_ram_q),
		.i_alu_result(m_alu_result),
		.i_alu_flags(m_alu_flags),
		.o_bus(m_bus),
		.o_mar(m_mar),
		.o_r0(m_r0),
		.o_r1(m_r1),
		.o_flags(m_flags)
	);

	// The ALU op is always the byte the RAM is reading
	cpu_alu u_alu (
		.i_a(m_r0),
		.i_b(m_r1),
		.i_op(m_ram_q),
		.o_result(m_alu_result),
		.o_flags(m_alu_flags)
	);

	cpu_ram u_ram (
		.i_clk(i_clk),
		.i_addr(m_mar),
		.i_wdata(m_bus),
		.i_we(m_ctrl.write_ram),
		.o_q(m_ram_q)
	);
endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic o_clk
);
	// 100 ns period
	initial o_clk = 1'b0;

	always #50 o_clk = ~o_clk;
endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
	localparam int num_tests = 5;

	logic clk;
	logic reset;
	logic load_addr;
	logic load_data;
	logic execute;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic waiting;

	// One check strobe per test and the byte it expects
	logic [num_tests-1:0] chk;
	logic [7:0] exp_byte;
	logic [7:0] prog [$];
	int cur_test;
	int errors;
	bit aborted;

	tb_clock u_clock (
		.o_clk(clk)
	);

	cpu_top uut (
		.i_clk(clk),
		.i_reset(reset),
		.i_load_addr(load_addr),
		.i_load_data(load_data),
		.i_execute(execute),
		.i_data_in(data_in),
		.o_data_out(data_out),
		.o_waiting(waiting)
	);

	function automatic string test_label(input int t);
		case (t)
			0: return "reset";
			1: return "loading";
			2: return "load_store";
			3: return "arithmetic";
			default: return "loop";
		endcase
	endfunction

	// Result of each ALU op over 8 bits
	function automatic logic [7:0] expected_alu(input logic [2:0] op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			cpu_pkg::alu_add: return a + b;
			cpu_pkg::alu_sub: return a - b;
			cpu_pkg::alu_and: return a & b;
			cpu_pkg::alu_or: return a | b;
			cpu_pkg::alu_xor: return a ^ b;
			default: return 8'h00;
		endcase
	endfunction

	task automatic report_mismatch(input logic [7:0] expected, input logic [7:0] actual);
		errors++;
		$display("CHECK FAILED %s expected %02h actual %02h", test_label(cur_test),
			expected, actual);
	endtask

	a_reset_waiting: assert property (@(posedge clk) chk[0] |-> waiting == exp_byte[0])
		else report_mismatch({7'd0, exp_byte[0]}, {7'd0, waiting});

	for (genvar t = 1; t < num_tests; t++) begin : g_byte_check
		a_byte: assert property (@(posedge clk) chk[t] |-> data_out == exp_byte)
			else report_mismatch(exp_byte, data_out);
	end

	// Inputs change 10 ns after the rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic pulse_check();
		if (aborted)
			return;
		chk[cur_test] = 1'b1;
		step(1);
		chk = '0;
	endtask

	task automatic load_byte(input logic [7:0] addr, input logic [7:0] value);
		data_in = addr;
		load_addr = 1'b1;
		step(2);
		load_addr = 1'b0;
		step(1);
		data_in = value;
		load_data = 1'b1;
		step(2);
		load_data = 1'b0;
		step(1);
	endtask

	task automatic check_byte(input logic [7:0] addr, input logic [7:0] expected);
		logic [7:0] seen;
		data_in = addr;
		load_addr = 1'b1;
		step(2);
		load_addr = 1'b0;
		step(2);
		exp_byte = expected;
		pulse_check();
		// Writing the byte back takes the panel out of data loading
		seen = data_out;
		data_in = seen;
		load_data = 1'b1;
		step(2);
		load_data = 1'b0;
		step(1);
	endtask

	task automatic emit(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
		input int len);
		prog.push_back(b0);
		if (len > 1)
			prog.push_back(b1);
		if (len > 2)
			prog.push_back(b2);
	endtask

	task automatic load_program();
		foreach (prog[i])
			load_byte(8'(i), prog[i]);
	endtask

	task automatic wait_until_waiting();
		int waited;
		waited = 0;
		while (!waiting && waited < 2000) begin
			step(1);
			waited++;
		end
		if (!waiting) begin
			errors++;
			aborted = 1'b1;
			$display("%s: the CPU did not return to waiting within 2000 cycles",
				test_label(cur_test));
		end
	endtask

	task automatic run_program();
		execute = 1'b1;
		step(2);
		execute = 1'b0;
		wait_until_waiting();
	endtask

	task automatic reset_and_halt();
		exp_byte = 8'h01;
		pulse_check();
		prog.delete();
		emit(cpu_pkg::op_halt, 8'h00, 8'h00, 1);
		load_program();
		// The CPU leaves waiting as soon as the execute press is seen
		execute = 1'b1;
		step(1);
		exp_byte = 8'h00;
		pulse_check();
		execute = 1'b0;
		wait_until_waiting();
	endtask

	task automatic read_back_bytes();
		logic [7:0] addrs [8];
		logic [7:0] model [256];
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 8'($urandom);
			model[addrs[i]] = 8'($urandom);
			load_byte(addrs[i], model[addrs[i]]);
		end
		for (int i = 0; i < 8; i++)
			check_byte(addrs[i], model[addrs[i]]);
	endtask

	task automatic store_register();
		logic [7:0] v;
		v = 8'($urandom);
		prog.delete();
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg2), v, 3);
		emit(cpu_pkg::op_stom, 8'(cpu_pkg::sel_reg2), 8'hc0, 3);
		emit(cpu_pkg::op_halt, 8'h00, 8'h00, 1);
		load_program();
		load_byte(8'hc0, ~v);
		run_program();
		check_byte(8'hc0, v);
	endtask

	task automatic math_results();
		logic [7:0] a;
		logic [7:0] b;
		a = 8'($urandom);
		b = 8'($urandom);
		prog.delete();
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg0), a, 3);
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg1), b, 3);
		// Each op result goes RAX to R3 to its own byte at e0 + op
		for (int k = 0; k < 5; k++) begin
			emit(cpu_pkg::op_math, 8'(k), 8'h00, 2);
			emit(cpu_pkg::op_cpfr, 8'(cpu_pkg::sel_reg3), 8'(cpu_pkg::sel_rax), 3);
			emit(cpu_pkg::op_stom, 8'(cpu_pkg::sel_reg3), 8'he0 + 8'(k), 3);
		end
		emit(cpu_pkg::op_halt, 8'h00, 8'h00, 1);
		load_program();
		for (int k = 0; k < 5; k++)
			load_byte(8'he0 + 8'(k), ~expected_alu(3'(k), a, b));
		run_program();
		for (int k = 0; k < 5; k++)
			check_byte(8'he0 + 8'(k), expected_alu(3'(k), a, b));
	endtask

	task automatic loop_and_jump();
		logic [7:0] n;
		logic [7:0] marker;
		n = 8'(1 + $urandom % 12);
		marker = 8'($urandom);
		prog.delete();
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg0), n, 3);
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg1), 8'h01, 3);
		// R0 counts down to zero in the loop that starts at address 6
		emit(cpu_pkg::op_math, 8'(cpu_pkg::alu_sub), 8'h00, 2);
		emit(cpu_pkg::op_cpfr, 8'(cpu_pkg::sel_reg0), 8'(cpu_pkg::sel_rax), 3);
		emit(cpu_pkg::op_jinz, 8'h06, 8'h00, 2);
		emit(cpu_pkg::op_noop, 8'h00, 8'h00, 1);
		emit(cpu_pkg::op_stom, 8'(cpu_pkg::sel_reg0), 8'hd0, 3);
		emit(cpu_pkg::op_ldfi, 8'(cpu_pkg::sel_reg2), marker, 3);
		emit(cpu_pkg::op_stom, 8'(cpu_pkg::sel_reg2), 8'hd1, 3);
		// Jump over a store to d2 and land on the HALT at 28
		emit(cpu_pkg::op_jump, 8'h1c, 8'h00, 2);
		emit(cpu_pkg::op_stom, 8'(cpu_pkg::sel_reg2), 8'hd2, 3);
		emit(cpu_pkg::op_halt, 8'h00, 8'h00, 1);
		load_program();
		load_byte(8'hd0, 8'hff);
		load_byte(8'hd1, ~marker);
		load_byte(8'hd2, 8'h5a);
		run_program();
		check_byte(8'hd0, 8'h00);
		check_byte(8'hd1, marker);
		check_byte(8'hd2, 8'h5a);
	endtask

	initial begin
		int start_errors;
		int passed;
		int failed;
		void'($urandom(64914));
		reset = 1'b1;
		load_addr = 1'b0;
		load_data = 1'b0;
		execute = 1'b0;
		data_in = 8'h00;
		chk = '0;
		exp_byte = 8'h00;
		errors = 0;
		aborted = 1'b0;
		cur_test = 0;
		passed = 0;
		failed = 0;
		step(16);
		reset = 1'b0;
		step(1);
		for (int t = 0; t < num_tests && !aborted; t++) begin
			cur_test = t;
			start_errors = errors;
			case (t)
				0: reset_and_halt();
				1: read_back_bytes();
				2: store_register();
				3: math_results();
				default: loop_and_jump();
			endcase
			if (errors == start_errors) begin
				passed++;
				$display("%s: ok", test_label(t));
			end else begin
				failed++;
				$display("%s: %0d errors", test_label(t), errors - start_errors);
			end
		end
		$display("%0d run, %0d passed, %0d failed", passed + failed, passed, failed);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

/* vlog.f */
cpu_pkg.sv
cpu_alu.sv
cpu_ram.sv
cpu_regs.sv
cpu_control.sv
cpu_top.sv
tb_clock.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_cpu -f vlog.f -o sim_cpu \
	&& ./obj_dir/sim_cpu | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
